/* filelist.f */
+incdir+verification
hdl/tank_pkg.sv
hdl/game_control.sv
hdl/player_tank.sv
hdl/bullet.sv
hdl/enemy_tank.sv
hdl/tank_game_top.sv
verification/tank_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tank game testbench with Verilator.
# Exit status is nonzero when the build fails or the log shows a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tank_game_tb \
	-o tank_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tank_sim > sim.log 2>&1 \
	|| { echo "simulation exited with an error"; cat sim.log; exit 1; }

cat sim.log

grep -q "Test failed" sim.log \
	&& { echo "failure found in sim.log"; exit 1; } \
	|| { echo "no failure found in sim.log"; exit 0; }

/* verification/tank_game_tests.svh */
//==================================================
// Directed tests for the tank game and the small
// player move model they predict from
//==================================================

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("[FAIL] %0t ns %s: got %0h expected %0h", $time, name, got, exp);
		errors++;
	end
endtask

// one cell step with clamping at the grid edge
function automatic pos_s move_cell(input pos_s p, input dir_e d);
	pos_s n;
	n = p;
	case (d)
		dir_up:    if (p.y != 5'd0) n.y = p.y - 5'd1;
		dir_down:  if (p.y != GRID_MAX) n.y = p.y + 5'd1;
		dir_left:  if (p.x != 5'd0) n.x = p.x - 5'd1;
		default:   if (p.x != GRID_MAX) n.x = p.x + 5'd1;
	endcase
	return n;
endfunction

task automatic step_cycles(input int n);
	repeat (n) @(negedge clk);
endtask

task automatic run_ticks(input int n);
	repeat (n) begin
		step_cycles(TICK_DIV);
		tick_now++;
	end
endtask

task automatic check_player(input pos_s exp);
	check_value("player_pos.x", 32'(player_pos.x), 32'(exp.x));
	check_value("player_pos.y", 32'(player_pos.y), 32'(exp.y));
endtask

// st press, then sync to the cycle after the start strobe
task automatic press_start();
	int waited;
	waited = 0;
	buttons.st = 1'b1;
	do begin
		@(negedge clk);
		waited++;
	end while (state != st_play && waited < 20);
	checks++;
	assert (state == st_play) else begin
		$display("st press did not bring the game into play");
		errors++;
	end
	buttons.st = 1'b0;
	step_cycles(1);
	tick_now = 0;
endtask

task automatic reset_and_start_test();
	check_value("state", 32'(state), 32'(st_idle));
	check_value("hp", 32'(hp), 32'(HP_INIT));
	check_value("score", 32'(score), 32'd0);
	check_value("bullet.active", 32'(bullet.active), 32'd0);
	check_value("alive", 32'(alive), 32'd0);
	check_player(PLAYER_HOME);
	check_value("player_dir", 32'(player_dir), 32'(dir_up));
	press_start();
	check_value("alive", 32'(alive), 32'((1 << N_ENEMY) - 1));
	for (int i = 0; i < N_ENEMY; i++) begin
		check_value("enemy_pos.x", 32'(enemy_pos[i].x), 32'(8 * i + 4));
		check_value("enemy_pos.y", 32'(enemy_pos[i].y), 32'd0);
	end
	check_player(PLAYER_HOME);
endtask

task automatic movement_test();
	pos_s exp;
	exp = PLAYER_HOME;
	buttons.d = 1'b1;
	for (int k = 0; k < 20; k++) begin
		exp = move_cell(exp, dir_right);
		run_ticks(1);
		check_player(exp);
	end
	check_value("player_pos.x", 32'(player_pos.x), 32'(GRID_MAX));
	check_value("player_dir", 32'(player_dir), 32'(dir_right));
	buttons.w = 1'b1; // w beats d
	for (int k = 0; k < 3; k++) begin
		exp = move_cell(exp, dir_up);
		run_ticks(1);
		check_player(exp);
	end
	check_value("player_dir", 32'(player_dir), 32'(dir_up));
	buttons = '0;
endtask

// column 31 holds no enemy
task automatic bullet_flight_test();
	pos_s exp;
	buttons.st = 1'b1;
	exp = player_pos;
	run_ticks(1);
	buttons.st = 1'b0;
	check_value("bullet.active", 32'(bullet.active), 32'd1);
	check_value("bullet.pos", 32'(bullet.pos), 32'(exp));
	check_value("bullet.dir", 32'(bullet.dir), 32'(dir_up));
	while (exp.y != 5'd0) begin
		exp.y = exp.y - 5'd1;
		run_ticks(1);
		check_value("bullet.active", 32'(bullet.active), 32'd1);
		check_value("bullet.pos", 32'(bullet.pos), 32'(exp));
	end
	run_ticks(1);
	check_value("bullet.active", 32'(bullet.active), 32'd0);
endtask

task automatic kill_respawn_test();
	int row;
	int meet;
	buttons.a = 1'b1;
	run_ticks(19); // x 31 down to 12
	buttons.a = 1'b0;
	buttons.w = 1'b1; // one row up turns the heading up for the shot
	run_ticks(1);
	buttons = '0;
	check_player(pos_s'{x: 5'd12, y: 5'd27});
	check_value("player_dir", 32'(player_dir), 32'(dir_up));
	// bullet and enemy close in by two rows per tick, so the gap must be even
	if (((27 - ((tick_now + 1) % 32)) % 2) != 0)
		run_ticks(1);
	buttons.st = 1'b1;
	run_ticks(1);
	buttons.st = 1'b0;
	row = tick_now % 32;
	meet = (27 - row) / 2;
	run_ticks(meet);
	check_value("bullet.pos.y", 32'(bullet.pos.y), 32'(27 - meet));
	check_value("enemy_pos[1].y", 32'(enemy_pos[1].y), 32'(row + meet));
	step_cycles(1);
	check_value("bullet.active", 32'(bullet.active), 32'd0);
	check_value("alive[1]", 32'(alive[1]), 32'd0);
	check_value("score", 32'(score), 32'd1);
	step_cycles(TICK_DIV - 1);
	tick_now++; // first tick spent dead
	for (int r = 1; r < RESPAWN_TICKS; r++) begin
		check_value("alive[1]", 32'(alive[1]), 32'd0);
		run_ticks(1);
	end
	check_value("alive[1]", 32'(alive[1]), 32'd1);
	check_value("enemy_pos[1]", 32'(enemy_pos[1]), 32'({5'd12, 5'd0}));
endtask

task automatic crash_over_restart_test();
	int crash_tick;
	int respawn_tick;
	respawn_tick = tick_now;
	for (int c = 1; c <= int'(HP_INIT); c++) begin
		crash_tick = respawn_tick + 27; // enemy row reaches the player
		run_ticks(crash_tick - tick_now);
		check_value("enemy_pos[1].y", 32'(enemy_pos[1].y), 32'd27);
		step_cycles(1);
		check_value("hp", 32'(hp), 32'(int'(HP_INIT) - c));
		check_value("alive[1]", 32'(alive[1]), 32'd0);
		step_cycles(TICK_DIV - 1);
		tick_now++;
		respawn_tick = crash_tick + RESPAWN_TICKS;
	end
	check_value("state", 32'(state), 32'(st_over));
	buttons.d = 1'b1;
	step_cycles(4 * TICK_DIV);
	check_player(pos_s'{x: 5'd12, y: 5'd27}); // no ticks in st_over
	buttons = '0;
	press_start();
	check_value("state", 32'(state), 32'(st_play));
	check_value("hp", 32'(hp), 32'(HP_INIT));
	check_value("score", 32'(score), 32'd1);
	check_player(PLAYER_HOME);
endtask

/* verification/tank_game_tb.sv */
//==================================================
// Tank game testbench: clock, reset, DUT, watchdog
// and the closing result of the directed tests
//==================================================
`timescale 1ns/10ps

module tank_game_tb;
	import tank_pkg::*;

	localparam int TICK_DIV = DEF_TICK_DIV;
	localparam hp_t HP_INIT = DEF_HP_INIT;
	localparam int RESPAWN_TICKS = DEF_RESPAWN_TICKS;
	localparam int N_ENEMY = DEF_N_ENEMY;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;

	// sum of the tests' tick budgets plus button presses and margin
	localparam int TICK_BUDGET = 240;
	localparam longint TIMEOUT_NS =
		64'(TICK_BUDGET * TICK_DIV + RESET_CYCLES + 200) * CLK_PERIOD;

	logic clk;
	logic arst_n;
	buttons_s buttons;
	game_state_e state;
	hp_t hp;
	score_t score;
	pos_s player_pos;
	dir_e player_dir;
	bullet_s bullet;
	logic [N_ENEMY-1:0] alive;
	pos_s enemy_pos [N_ENEMY];

	int errors;
	int checks;
	int tick_now; // ticks since the last start strobe

	tank_game_top #(
		.TICK_DIV      (TICK_DIV),
		.HP_INIT       (HP_INIT),
		.RESPAWN_TICKS (RESPAWN_TICKS),
		.N_ENEMY       (N_ENEMY)
	) UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.buttons    (buttons),
		.state      (state),
		.hp         (hp),
		.score      (score),
		.player_pos (player_pos),
		.player_dir (player_dir),
		.bullet     (bullet),
		.alive      (alive),
		.enemy_pos  (enemy_pos)
	);

	`include "tank_game_tests.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		buttons = '0;
		errors = 0;
		checks = 0;
		tick_now = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		reset_and_start_test();
		movement_test();
		bullet_flight_test();
		kill_respawn_test();
		crash_over_restart_test();

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* hdl/tank_game_top.sv */
//==================================================
// Tank game top: controller, player, bullet and
// the row of enemy tanks
//==================================================
`timescale 1ns/10ps

module tank_game_top #(
	parameter int TICK_DIV = tank_pkg::DEF_TICK_DIV,
	parameter tank_pkg::hp_t HP_INIT = tank_pkg::DEF_HP_INIT,
	parameter int RESPAWN_TICKS = tank_pkg::DEF_RESPAWN_TICKS,
	parameter int N_ENEMY = tank_pkg::DEF_N_ENEMY
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  tank_pkg::buttons_s    buttons,
	output tank_pkg::game_state_e state,
	output tank_pkg::hp_t         hp,
	output tank_pkg::score_t      score,
	output tank_pkg::pos_s        player_pos,
	output tank_pkg::dir_e        player_dir,
	output tank_pkg::bullet_s     bullet,
	output logic [N_ENEMY-1:0]    alive,
	output tank_pkg::pos_s        enemy_pos [N_ENEMY]
);
	import tank_pkg::*;

	logic start;
	logic tick;
	logic fire;
	logic hit;
	logic [N_ENEMY-1:0] kill;
	logic [N_ENEMY-1:0] crash;

	assign hit = |kill; // any enemy struck retires the bullet

	game_control #(
		.TICK_DIV (TICK_DIV),
		.HP_INIT  (HP_INIT),
		.N_ENEMY  (N_ENEMY)
	) u_game_control (
		.clk    (clk),
		.arst_n (arst_n),
		.st     (buttons.st),
		.kill   (kill),
		.crash  (crash),
		.start  (start),
		.tick   (tick),
		.state  (state),
		.hp     (hp),
		.score  (score)
	);

	player_tank u_player_tank (
		.clk           (clk),
		.arst_n        (arst_n),
		.start         (start),
		.tick          (tick),
		.buttons       (buttons),
		.bullet_active (bullet.active),
		.player_pos    (player_pos),
		.player_dir    (player_dir),
		.fire          (fire)
	);

	bullet u_bullet (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.tick       (tick),
		.fire       (fire),
		.player_pos (player_pos),
		.player_dir (player_dir),
		.hit        (hit),
		.bullet     (bullet)
	);

	// enemies spread over columns 4, 12, 20, 28
	for (genvar i = 0; i < N_ENEMY; i++) begin : g_enemy
		enemy_tank #(
			.SPAWN_COL     (coord_t'(8 * i + 4)),
			.RESPAWN_TICKS (RESPAWN_TICKS)
		) u_enemy_tank (
			.clk        (clk),
			.arst_n     (arst_n),
			.start      (start),
			.tick       (tick),
			.bullet     (bullet),
			.player_pos (player_pos),
			.alive      (alive[i]),
			.enemy_pos  (enemy_pos[i]),
			.kill       (kill[i]),
			.crash      (crash[i])
		);
	end

endmodule

/* hdl/enemy_tank.sv */
//==================================================
// Enemy tank: marches down its column, dies on a
// bullet hit or a ram, respawns after a delay
//==================================================
`timescale 1ns/10ps

module enemy_tank #(
	parameter tank_pkg::coord_t SPAWN_COL = 5'd4,
	parameter int RESPAWN_TICKS = tank_pkg::DEF_RESPAWN_TICKS
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  logic              tick,
	input  tank_pkg::bullet_s bullet,
	input  tank_pkg::pos_s    player_pos,
	output logic              alive,
	output tank_pkg::pos_s    enemy_pos,
	output logic              kill,
	output logic              crash
);
	import tank_pkg::*;

	localparam int WAIT_W = (RESPAWN_TICKS > 1) ? $clog2(RESPAWN_TICKS) : 1;
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(RESPAWN_TICKS - 1);

	logic alive_q;
	coord_t row_q;
	logic [WAIT_W-1:0] wait_cnt;

	assign enemy_pos = '{x: SPAWN_COL, y: row_q};

	// collisions on registered positions, bullet first
	assign kill = alive_q && bullet.active && (bullet.pos == enemy_pos);
	assign crash = alive_q && (player_pos == enemy_pos) && !kill;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alive_q <= 1'b0;
			row_q <= '0;
			wait_cnt <= '0;
		end else if (start) begin
			alive_q <= 1'b1;
			row_q <= '0;
			wait_cnt <= '0;
		end else if (kill || crash) begin
			alive_q <= 1'b0;
			wait_cnt <= '0;
		end else if (tick) begin
			if (alive_q) begin
				row_q <= (row_q == GRID_MAX) ? '0 : row_q + 1'b1; // wraps to the top
			end else if (wait_cnt == WAIT_LAST) begin
				alive_q <= 1'b1; // back at the top of its column
				row_q <= '0;
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	assign alive = alive_q;

endmodule

/* hdl/bullet.sv */
//==================================================
// Player bullet: launched on fire, one cell per
// tick, retired at the grid edge or on a hit
//==================================================
`timescale 1ns/10ps

module bullet (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  logic              tick,
	input  logic              fire,
	input  tank_pkg::pos_s    player_pos,
	input  tank_pkg::dir_e    player_dir,
	input  logic              hit,
	output tank_pkg::bullet_s bullet
);
	import tank_pkg::*;

	logic active_q;
	pos_s pos_q;
	pos_s pos_step;
	dir_e dir_q;
	logic at_edge;

	// next cell in flight, and whether that step leaves the grid
	always_comb begin
		pos_step = pos_q;
		at_edge = 1'b0;
		case (dir_q)
			dir_up: begin
				at_edge = (pos_q.y == '0);
				pos_step.y = pos_q.y - 1'b1;
			end
			dir_down: begin
				at_edge = (pos_q.y == GRID_MAX);
				pos_step.y = pos_q.y + 1'b1;
			end
			dir_left: begin
				at_edge = (pos_q.x == '0);
				pos_step.x = pos_q.x - 1'b1;
			end
			default: begin
				at_edge = (pos_q.x == GRID_MAX);
				pos_step.x = pos_q.x + 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			active_q <= 1'b0;
		else if (start || hit)
			active_q <= 1'b0;
		else if (fire)
			active_q <= 1'b1;
		else if (tick && active_q && at_edge)
			active_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			pos_q <= player_pos;
			dir_q <= player_dir;
		end else if (tick && active_q) begin
			pos_q <= pos_step;
		end
	end

	assign bullet = '{active: active_q, pos: pos_q, dir: dir_q};

endmodule

/* hdl/player_tank.sv */
//==================================================
// Player tank: moves one cell per tick by the held
// buttons, and requests a bullet launch
//==================================================
`timescale 1ns/10ps

module player_tank (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  logic               tick,
	input  tank_pkg::buttons_s buttons,
	input  logic               bullet_active,
	output tank_pkg::pos_s     player_pos,
	output tank_pkg::dir_e     player_dir,
	output logic               fire
);
	import tank_pkg::*;

	pos_s pos_q;
	pos_s pos_nxt;
	dir_e dir_q;
	dir_e dir_nxt;
	logic move;

	always_comb begin
		dir_nxt = dir_q;
		pos_nxt = pos_q;
		move = 1'b1;
		// w wins over s, then a, then d
		if (buttons.w)
			dir_nxt = dir_up;
		else if (buttons.s)
			dir_nxt = dir_down;
		else if (buttons.a)
			dir_nxt = dir_left;
		else if (buttons.d)
			dir_nxt = dir_right;
		else
			move = 1'b0;

		if (move) begin
			case (dir_nxt)
				dir_up:    if (pos_q.y != '0) pos_nxt.y = pos_q.y - 1'b1;
				dir_down:  if (pos_q.y != GRID_MAX) pos_nxt.y = pos_q.y + 1'b1;
				dir_left:  if (pos_q.x != '0) pos_nxt.x = pos_q.x - 1'b1;
				dir_right: if (pos_q.x != GRID_MAX) pos_nxt.x = pos_q.x + 1'b1;
				default:   pos_nxt = pos_q;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos_q <= PLAYER_HOME;
			dir_q <= PLAYER_HOME_DIR;
		end else if (start) begin
			pos_q <= PLAYER_HOME; // re-home on every new game
			dir_q <= PLAYER_HOME_DIR;
		end else if (tick) begin
			pos_q <= pos_nxt;
			dir_q <= dir_nxt; // heading turns even when blocked
		end
	end

	// bullet samples pos_q/dir_q on this same edge, so it leaves
	// from the cell before the move
	assign fire = tick & buttons.st & ~bullet_active;

	assign player_pos = pos_q;
	assign player_dir = dir_q;

endmodule

/* hdl/game_control.sv */
//==================================================
// Classic mode controller: idle/play/over FSM,
// move tick divider, HP and score counters
//==================================================
`timescale 1ns/10ps

module game_control #(
	parameter int TICK_DIV = tank_pkg::DEF_TICK_DIV,
	parameter tank_pkg::hp_t HP_INIT = tank_pkg::DEF_HP_INIT,
	parameter int N_ENEMY = tank_pkg::DEF_N_ENEMY
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  st,
	input  logic [N_ENEMY-1:0]    kill,
	input  logic [N_ENEMY-1:0]    crash,
	output logic                  start,
	output logic                  tick,
	output tank_pkg::game_state_e state,
	output tank_pkg::hp_t         hp,
	output tank_pkg::score_t      score
);
	import tank_pkg::*;

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);
	localparam int SCORE_MAX = 2 ** $bits(score_t) - 1;

	logic st_q;
	logic st_rise;
	logic start_now;
	logic going_over;
	logic [CNT_W-1:0] cnt;
	int kill_n;
	int crash_n;
	int score_sum;
	hp_t hp_next;
	score_t score_next;

	assign st_rise = st & ~st_q;
	assign start_now = (state != st_play) && st_rise; // from idle or over

	// count how many enemies were killed / rammed this cycle
	always_comb begin
		kill_n = 0;
		crash_n = 0;
		for (int i = 0; i < N_ENEMY; i++) begin
			kill_n += int'(kill[i]);
			crash_n += int'(crash[i]);
		end
	end

	// both counters saturate
	always_comb begin
		score_sum = int'(score) + kill_n;
		score_next = (score_sum > SCORE_MAX) ? score_t'(SCORE_MAX) : score_t'(score_sum);
		hp_next = (crash_n >= int'(hp)) ? '0 : hp_t'(int'(hp) - crash_n);
	end

	assign going_over = (state == st_play) && (crash_n != 0) && (hp_next == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st_q <= 1'b0;
			state <= st_idle;
			start <= 1'b0;
			hp <= HP_INIT;
		end else begin
			st_q <= st;
			start <= 1'b0;
			case (state)
				st_idle, st_over: begin
					if (start_now) begin
						state <= st_play;
						start <= 1'b1;
						hp <= HP_INIT; // score carries over
					end
				end
				st_play: begin
					hp <= hp_next;
					if (going_over)
						state <= st_over;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			score <= '0;
		else if (state == st_play)
			score <= score_next;
	end

	// move tick, first one TICK_DIV cycles after start
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= (state == st_play) && !going_over && (cnt == CNT_LAST);
			if (start_now)
				cnt <= '0;
			else if (state == st_play)
				cnt <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
		end
	end

endmodule

/* hdl/tank_pkg.sv */
//==================================================
// Tank game shared types: grid cells, headings,
// game states, status structs and default settings
//==================================================

package tank_pkg;

	// grid is 32 x 32 cells
	typedef logic [4:0] coord_t;
	typedef logic [4:0] hp_t;
	typedef logic [5:0] score_t;

	typedef enum logic [1:0] {
		dir_up,
		dir_down,
		dir_left,
		dir_right
	} dir_e;

	typedef enum logic [1:0] {
		st_idle,
		st_play,
		st_over
	} game_state_e;

	typedef struct packed {
		coord_t x;
		coord_t y; // row 0 is the top edge
	} pos_s;

	// held levels from the board buttons
	typedef struct packed {
		logic w;
		logic a;
		logic s;
		logic d;
		logic st; // start in idle/over, shoot in play
	} buttons_s;

	typedef struct packed {
		logic active;
		pos_s pos;
		dir_e dir;
	} bullet_s;

	localparam coord_t GRID_MAX = 5'd31;

	localparam pos_s PLAYER_HOME = '{x: 5'd16, y: 5'd31}; // bottom middle
	localparam dir_e PLAYER_HOME_DIR = dir_up;

	// defaults picked up by the top level
	localparam int DEF_TICK_DIV = 8;
	localparam hp_t DEF_HP_INIT = 5'd3;
	localparam int DEF_RESPAWN_TICKS = 4;
	localparam int DEF_N_ENEMY = 4;

endpackage
